/* bench/noc_wb_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_wb_bridge_properties
  import noc_types_pkg::*;
(
  input logic          i_clk,
  input logic          i_rst_n,
  input logic          i_s_stb,
  input logic          i_s_ack,
  input logic          i_s_err,
  input logic          i_req_valid,
  input logic          i_req_ready,
  input noc_req_flit_t i_req_flit,
  input logic          i_rsp_valid,
  input logic          i_rsp_ready,
  input noc_rsp_flit_t i_rsp_flit,
  input logic          i_m_stb,
  input noc_addr_t     i_m_adr,
  input logic          i_m_ack
);

  int fail_count = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // initiator side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_s_ack && i_s_err))
    else begin
      $error("ack and err high together");
      fail_count = fail_count + 1;
    end

  reply_needs_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_s_ack || i_s_err) |-> i_s_stb)
    else begin
      $error("ack or err without stb");
      fail_count = fail_count + 1;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit links.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  req_flit_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_req_valid && !i_req_ready) |=> (i_req_valid && $stable(i_req_flit)))
    else begin
      $error("request flit dropped or changed before ready");
      fail_count = fail_count + 1;
    end

  rsp_flit_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp_flit)))
    else begin
      $error("response flit dropped or changed before ready");
      fail_count = fail_count + 1;
    end

  // target cycle holds until ack.
  target_stb_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_m_stb && !i_m_ack) |=> (i_m_stb && $stable(i_m_adr)))
    else begin
      $error("target stb dropped before ack");
      fail_count = fail_count + 1;
    end

endmodule

bind noc_wb_bridge_top noc_wb_bridge_properties u_properties (
  .i_clk       (i_clk        ),
  .i_rst_n     (i_rst_n      ),
  .i_s_stb     (i_s_stb      ),
  .i_s_ack     (o_s_ack      ),
  .i_s_err     (o_s_err      ),
  .i_req_valid (sa_req_valid ),
  .i_req_ready (sa_req_ready ),
  .i_req_flit  (sa_req_flit  ),
  .i_rsp_valid (ma_rsp_valid ),
  .i_rsp_ready (ma_rsp_ready ),
  .i_rsp_flit  (ma_rsp_flit  ),
  .i_m_stb     (o_m_stb      ),
  .i_m_adr     (o_m_adr      ),
  .i_m_ack     (i_m_ack      )
);

`default_nettype wire

/* bench/noc_wb_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_wb_bridge_tb
  import noc_types_pkg::*;
();

  localparam int          CLK_PERIOD     = 40;
  localparam int          RESET_CYCLES   = 10;
  localparam int          CYCLES_PER_ROW = 40;
  localparam int          NUM_PASSES     = 2;
  localparam int          MAX_WAIT       = 3;
  localparam logic [31:0] SEED           = 32'hc9a1_b055;

  typedef struct packed {
    logic      we;
    noc_addr_t adr;
    noc_sel_t  sel;
    noc_data_t wdat;
    logic      exp_err;
    noc_data_t exp_rdat;
  } row_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      s_cyc;
  logic      s_stb;
  logic      s_we;
  noc_addr_t s_adr;
  noc_sel_t  s_sel;
  noc_data_t s_dat;
  noc_data_t s_rdat;
  logic      s_ack;
  logic      s_err;
  logic      m_cyc;
  logic      m_stb;
  logic      m_we;
  noc_addr_t m_adr;
  noc_sel_t  m_sel;
  noc_data_t m_wdat;
  noc_data_t m_rdat;
  logic      m_ack;

  row_t      table_rows[$];
  int        error_count = 0;
  int        check_count = 0;
  int        test_count  = 0;
  int        timeout_limit = 0;
  int        cycle_count;
  noc_data_t target_mem [16];
  logic      target_busy;
  int        target_wait;
  int        target_cycles;
  logic [3:0] target_idx;

  always #(CLK_PERIOD / 2) clk = ~clk;

  noc_wb_bridge_top i_dut (
    .i_clk   (clk    ),
    .i_rst_n (rst_n  ),
    .i_s_cyc (s_cyc  ),
    .i_s_stb (s_stb  ),
    .i_s_we  (s_we   ),
    .i_s_adr (s_adr  ),
    .i_s_sel (s_sel  ),
    .i_s_dat (s_dat  ),
    .o_s_dat (s_rdat ),
    .o_s_ack (s_ack  ),
    .o_s_err (s_err  ),
    .o_m_cyc (m_cyc  ),
    .o_m_stb (m_stb  ),
    .o_m_we  (m_we   ),
    .o_m_adr (m_adr  ),
    .o_m_sel (m_sel  ),
    .o_m_dat (m_wdat ),
    .i_m_dat (m_rdat ),
    .i_m_ack (m_ack  )
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic noc_data_t fill_word(input int idx);
    return (noc_data_t'(idx) * 32'h0001_0205) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic noc_data_t merge_bytes(input noc_data_t old_word,
                                            input noc_data_t new_word,
                                            input noc_sel_t  sel);
    noc_data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic add_row(input logic we, input noc_addr_t adr, input noc_sel_t sel,
                         input noc_data_t wdat, input logic exp_err,
                         input noc_data_t exp_rdat);
    row_t row;
    row.we       = we;
    row.adr      = adr;
    row.sel      = sel;
    row.wdat     = wdat;
    row.exp_err  = exp_err;
    row.exp_rdat = exp_rdat;
    table_rows.push_back(row);
  endtask

  task automatic build_table();
    noc_data_t word3;
    noc_data_t word12;
    word3  = merge_bytes(32'h1122_3344, 32'haabb_ccdd, 4'b0101);
    word12 = merge_bytes(fill_word(12), 32'h0000_0077, 4'b0001);
    // region 0 reaches the target.
    add_row(1'b1, 32'h0000_0010, 4'hf, 32'hdead_beef, 1'b0, '0);
    add_row(1'b0, 32'h0000_0010, 4'hf, '0, 1'b0, 32'hdead_beef);
    add_row(1'b1, 32'h0000_000c, 4'hf, 32'h1122_3344, 1'b0, '0);
    add_row(1'b1, 32'h0000_000c, 4'b0101, 32'haabb_ccdd, 1'b0, '0);
    add_row(1'b0, 32'h0000_000c, 4'hf, '0, 1'b0, word3);
    add_row(1'b1, 32'h0000_000c, 4'b1010, 32'h5566_7788, 1'b0, '0);
    word3 = merge_bytes(word3, 32'h5566_7788, 4'b1010);
    add_row(1'b0, 32'h0000_000c, 4'hf, '0, 1'b0, word3);
    add_row(1'b0, 32'h0000_003c, 4'hf, '0, 1'b0, fill_word(15));
    // regions 1 and 2 live elsewhere and region 3 is unmapped.
    add_row(1'b1, 32'h4000_0008, 4'hf, 32'h0bad_f00d, 1'b1, '0);
    add_row(1'b0, 32'h4000_0008, 4'hf, '0, 1'b1, '0);
    add_row(1'b0, 32'h8000_000c, 4'hf, '0, 1'b1, '0);
    add_row(1'b1, 32'hc000_0004, 4'hf, 32'hcafe_0001, 1'b1, '0);
    add_row(1'b0, 32'hc000_0000, 4'hf, '0, 1'b1, '0);
    add_row(1'b0, 32'h0000_0008, 4'hf, '0, 1'b0, fill_word(2));
    add_row(1'b0, 32'h0000_0004, 4'hf, '0, 1'b0, fill_word(1));
    add_row(1'b1, 32'h0000_0030, 4'b0001, 32'h0000_0077, 1'b0, '0);
    add_row(1'b0, 32'h0000_0030, 4'hf, '0, 1'b0, word12);
  endtask

  // one classic cycle on the initiator side.
  task automatic run_row(input int pass_idx, input int row_idx);
    row_t      row;
    int        errors_before;
    int        target_before;
    logic      got_ack;
    logic      got_err;
    noc_data_t got_dat;
    row           = table_rows[row_idx];
    errors_before = error_count;
    target_before = target_cycles;
    @(posedge clk);
    #1;
    s_cyc = 1'b1;
    s_stb = 1'b1;
    s_we  = row.we;
    s_adr = row.adr;
    s_sel = row.sel;
    s_dat = row.wdat;
    do begin
      @(posedge clk);
      #1;
    end while (!s_ack && !s_err);
    got_ack = s_ack;
    got_err = s_err;
    got_dat = s_rdat;
    // ack is sampled on the next edge and then the cycle ends.
    @(posedge clk);
    #1;
    s_cyc = 1'b0;
    s_stb = 1'b0;
    s_we  = 1'b0;
    check_value("o_s_err", 32'(got_err), 32'(row.exp_err));
    check_value("o_s_ack", 32'(got_ack), 32'(!row.exp_err));
    if (!row.we && !row.exp_err) begin
      check_value("o_s_dat", got_dat, row.exp_rdat);
    end
    check_value("target cycles", 32'(target_cycles - target_before),
                row.exp_err ? 32'd0 : 32'd1);
    test_count = test_count + 1;
    $display("test %0d.%0d %s adr 0x%h: %s", pass_idx, row_idx,
             row.we ? "write" : "read", row.adr,
             (error_count == errors_before) ? "ok" : "mismatch");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // target memory model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    void'($urandom(SEED));
    m_ack         = 1'b0;
    m_rdat        = '0;
    target_busy   = 1'b0;
    target_wait   = 0;
    target_cycles = 0;
    target_idx    = '0;
    for (int i = 0; i < 16; i++) begin
      target_mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #1;
      if (m_ack) begin
        m_ack = 1'b0;
      end else if (m_cyc && m_stb) begin
        if (!target_busy) begin
          target_busy   = 1'b1;
          target_wait   = int'($urandom % (MAX_WAIT + 1));
          target_cycles = target_cycles + 1;
        end
        if (target_wait == 0) begin
          target_idx = m_adr[5:2];
          if (m_we) begin
            for (int b = 0; b < 4; b++) begin
              if (m_sel[b]) begin
                target_mem[target_idx][b*8 +: 8] = m_wdat[b*8 +: 8];
              end
            end
            m_rdat = '0;
          end else begin
            m_rdat = target_mem[target_idx];
          end
          m_ack       = 1'b1;
          target_busy = 1'b0;
        end else begin
          target_wait = target_wait - 1;
        end
      end
    end
  end

  // hang guard.
  initial begin
    cycle_count = 0;
    wait (timeout_limit > 0);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("TESTS FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst_n = 1'b0;
    s_cyc = 1'b0;
    s_stb = 1'b0;
    s_we  = 1'b0;
    s_adr = '0;
    s_sel = '0;
    s_dat = '0;
    build_table();
    timeout_limit = table_rows.size() * NUM_PASSES * CYCLES_PER_ROW + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value("o_s_ack", 32'(s_ack), 32'd0);
    check_value("o_s_err", 32'(s_err), 32'd0);
    check_value("o_m_cyc", 32'(m_cyc), 32'd0);
    check_value("o_m_stb", 32'(m_stb), 32'd0);
    test_count = test_count + 1;
    $display("test reset: %s", (error_count == 0) ? "ok" : "mismatch");
    // second pass sees other wait states.
    for (int p = 0; p < NUM_PASSES; p++) begin
      for (int r = 0; r < table_rows.size(); r++) begin
        run_row(p, r);
      end
    end
    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_count, check_count, error_count, i_dut.u_properties.fail_count);
    if (error_count == 0 && i_dut.u_properties.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/noc_types_pkg.sv
source/noc_map_pkg.sv
source/noc_wb_slave_adapter.sv
source/noc_flit_fifo.sv
source/noc_wb_master_adapter.sv
source/noc_wb_bridge_top.sv
bench/noc_wb_bridge_properties.sv
bench/noc_wb_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
  --top-module noc_wb_bridge_tb \
  -Mdir "$OBJ_DIR" -o noc_wb_bridge_sim \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/noc_wb_bridge_sim" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* source/noc_flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_flit_fifo #(
  parameter int WIDTH      = 8,
  parameter int FIFO_DEPTH = 4
)(
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_ready,
  output logic             o_valid,
  output logic [WIDTH-1:0] o_data,
  input  logic             i_ready
);

  localparam int               PTR_W      = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0]   FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  logic [WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign o_ready = (count != FULL_COUNT);
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and occupancy.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // depth is a power of two so pointers wrap on their own.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

`default_nettype wire

/* source/noc_map_pkg.sv */
`default_nettype none

package noc_map_pkg;

  import noc_types_pkg::*;

  // region index sits in the top two address bits.
  localparam int REGION_MSB = 30;

  typedef logic [1:0] noc_region_t;

  localparam noc_region_t REGION0 = 2'd0;
  localparam noc_region_t REGION1 = 2'd1;
  localparam noc_region_t REGION2 = 2'd2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // endpoint locations.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam noc_id_x_t REGION0_ID_X = 2'd1;
  localparam noc_id_y_t REGION0_ID_Y = 2'd0;

  localparam noc_id_x_t REGION1_ID_X = 2'd0;
  localparam noc_id_y_t REGION1_ID_Y = 2'd1;

  localparam noc_id_x_t REGION2_ID_X = 2'd2;
  localparam noc_id_y_t REGION2_ID_Y = 2'd1;

  // region 3 has no endpoint.

endpackage

`default_nettype wire

/* source/noc_types_pkg.sv */
`default_nettype none

package noc_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and location widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] noc_addr_t;
  typedef logic [31:0] noc_data_t;
  typedef logic [3:0]  noc_sel_t;
  typedef logic [1:0]  noc_id_x_t;
  typedef logic [1:0]  noc_id_y_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit layouts.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int REQ_FLIT_WIDTH = 73;
  localparam int RSP_FLIT_WIDTH = 33;

  typedef logic [REQ_FLIT_WIDTH-1:0] noc_req_flit_t;
  typedef logic [RSP_FLIT_WIDTH-1:0] noc_rsp_flit_t;

  // request: {we, sel, dst_x, dst_y, addr, wdata}.
  localparam int REQ_DATA_LSB  = 0;
  localparam int REQ_DATA_MSB  = 31;
  localparam int REQ_ADDR_LSB  = 32;
  localparam int REQ_ADDR_MSB  = 63;
  localparam int REQ_DST_Y_LSB = 64;
  localparam int REQ_DST_Y_MSB = 65;
  localparam int REQ_DST_X_LSB = 66;
  localparam int REQ_DST_X_MSB = 67;
  localparam int REQ_SEL_LSB   = 68;
  localparam int REQ_SEL_MSB   = 71;
  localparam int REQ_WE_BIT    = 72;

  // response: {err, rdata}.
  localparam int RSP_DATA_LSB = 0;
  localparam int RSP_DATA_MSB = 31;
  localparam int RSP_ERR_BIT  = 32;

  typedef enum logic [1:0] {
    SLAVE_IDLE,
    SLAVE_SEND,
    SLAVE_WAIT_RSP,
    SLAVE_DONE
  } slave_state_e;

  typedef enum logic [1:0] {
    MASTER_IDLE,
    MASTER_BUS,
    MASTER_REPLY
  } master_state_e;

endpackage

`default_nettype wire

/* source/noc_wb_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_wb_bridge_top
  import noc_types_pkg::*, noc_map_pkg::*;
#(
  parameter int        FIFO_DEPTH = 4,
  parameter noc_id_x_t LOCAL_ID_X = REGION0_ID_X,
  parameter noc_id_y_t LOCAL_ID_Y = REGION0_ID_Y
)(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_s_cyc,
  input  logic      i_s_stb,
  input  logic      i_s_we,
  input  noc_addr_t i_s_adr,
  input  noc_sel_t  i_s_sel,
  input  noc_data_t i_s_dat,
  output noc_data_t o_s_dat,
  output logic      o_s_ack,
  output logic      o_s_err,
  output logic      o_m_cyc,
  output logic      o_m_stb,
  output logic      o_m_we,
  output noc_addr_t o_m_adr,
  output noc_sel_t  o_m_sel,
  output noc_data_t o_m_dat,
  input  noc_data_t i_m_dat,
  input  logic      i_m_ack
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and response links.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic          sa_req_valid;
  noc_req_flit_t sa_req_flit;
  logic          sa_req_ready;
  logic          ma_req_valid;
  noc_req_flit_t ma_req_flit;
  logic          ma_req_ready;
  logic          ma_rsp_valid;
  noc_rsp_flit_t ma_rsp_flit;
  logic          ma_rsp_ready;
  logic          sa_rsp_valid;
  noc_rsp_flit_t sa_rsp_flit;
  logic          sa_rsp_ready;

  noc_wb_slave_adapter u_slave_adapter (
    .i_clk       (i_clk        ),
    .i_rst_n     (i_rst_n      ),
    .i_s_cyc     (i_s_cyc      ),
    .i_s_stb     (i_s_stb      ),
    .i_s_we      (i_s_we       ),
    .i_s_adr     (i_s_adr      ),
    .i_s_sel     (i_s_sel      ),
    .i_s_dat     (i_s_dat      ),
    .o_s_dat     (o_s_dat      ),
    .o_s_ack     (o_s_ack      ),
    .o_s_err     (o_s_err      ),
    .o_req_valid (sa_req_valid ),
    .o_req_flit  (sa_req_flit  ),
    .i_req_ready (sa_req_ready ),
    .i_rsp_valid (sa_rsp_valid ),
    .i_rsp_flit  (sa_rsp_flit  ),
    .o_rsp_ready (sa_rsp_ready )
  );

  noc_flit_fifo #(
    .WIDTH      (REQ_FLIT_WIDTH ),
    .FIFO_DEPTH (FIFO_DEPTH     )
  ) u_req_fifo (
    .i_clk   (i_clk        ),
    .i_rst_n (i_rst_n      ),
    .i_valid (sa_req_valid ),
    .i_data  (sa_req_flit  ),
    .o_ready (sa_req_ready ),
    .o_valid (ma_req_valid ),
    .o_data  (ma_req_flit  ),
    .i_ready (ma_req_ready )
  );

  noc_flit_fifo #(
    .WIDTH      (RSP_FLIT_WIDTH ),
    .FIFO_DEPTH (FIFO_DEPTH     )
  ) u_rsp_fifo (
    .i_clk   (i_clk        ),
    .i_rst_n (i_rst_n      ),
    .i_valid (ma_rsp_valid ),
    .i_data  (ma_rsp_flit  ),
    .o_ready (ma_rsp_ready ),
    .o_valid (sa_rsp_valid ),
    .o_data  (sa_rsp_flit  ),
    .i_ready (sa_rsp_ready )
  );

  noc_wb_master_adapter #(
    .LOCAL_ID_X (LOCAL_ID_X ),
    .LOCAL_ID_Y (LOCAL_ID_Y )
  ) u_master_adapter (
    .i_clk       (i_clk        ),
    .i_rst_n     (i_rst_n      ),
    .i_req_valid (ma_req_valid ),
    .i_req_flit  (ma_req_flit  ),
    .o_req_ready (ma_req_ready ),
    .o_rsp_valid (ma_rsp_valid ),
    .o_rsp_flit  (ma_rsp_flit  ),
    .i_rsp_ready (ma_rsp_ready ),
    .o_m_cyc     (o_m_cyc      ),
    .o_m_stb     (o_m_stb      ),
    .o_m_we      (o_m_we       ),
    .o_m_adr     (o_m_adr      ),
    .o_m_sel     (o_m_sel      ),
    .o_m_dat     (o_m_dat      ),
    .i_m_dat     (i_m_dat      ),
    .i_m_ack     (i_m_ack      )
  );

endmodule

`default_nettype wire

/* source/noc_wb_master_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_wb_master_adapter
  import noc_types_pkg::*;
#(
  parameter noc_id_x_t LOCAL_ID_X = 2'd1,
  parameter noc_id_y_t LOCAL_ID_Y = 2'd0
)(
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_req_valid,
  input  noc_req_flit_t i_req_flit,
  output logic          o_req_ready,
  output logic          o_rsp_valid,
  output noc_rsp_flit_t o_rsp_flit,
  input  logic          i_rsp_ready,
  output logic          o_m_cyc,
  output logic          o_m_stb,
  output logic          o_m_we,
  output noc_addr_t     o_m_adr,
  output noc_sel_t      o_m_sel,
  output noc_data_t     o_m_dat,
  input  noc_data_t     i_m_dat,
  input  logic          i_m_ack
);

  master_state_e state;
  logic          req_take;
  logic          dst_match;
  logic          bus_done;
  noc_req_flit_t req_q;
  logic          rsp_err_q;
  noc_data_t     rsp_data_q;

  assign req_take  = (state == MASTER_IDLE) && i_req_valid;
  assign bus_done  = (state == MASTER_BUS) && i_m_ack;
  assign dst_match = (i_req_flit[REQ_DST_X_MSB:REQ_DST_X_LSB] == LOCAL_ID_X) &&
                     (i_req_flit[REQ_DST_Y_MSB:REQ_DST_Y_LSB] == LOCAL_ID_Y);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= MASTER_IDLE;
    end else begin
      case (state)
        MASTER_IDLE: begin
          if (req_take) begin
            // wrong destination skips the bus and replies with err.
            state <= dst_match ? MASTER_BUS : MASTER_REPLY;
          end
        end
        MASTER_BUS: begin
          if (i_m_ack) begin
            state <= MASTER_REPLY;
          end
        end
        MASTER_REPLY: begin
          if (i_rsp_ready) begin
            state <= MASTER_IDLE;
          end
        end
        default: state <= MASTER_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_take) begin
      req_q      <= i_req_flit;
      rsp_err_q  <= !dst_match;
      rsp_data_q <= '0;
    end else if (bus_done) begin
      rsp_data_q <= i_m_dat;
    end
  end

  // target bus, driven straight from the held flit.
  assign o_m_cyc = (state == MASTER_BUS);
  assign o_m_stb = (state == MASTER_BUS);
  assign o_m_we  = req_q[REQ_WE_BIT];
  assign o_m_sel = req_q[REQ_SEL_MSB:REQ_SEL_LSB];
  assign o_m_adr = req_q[REQ_ADDR_MSB:REQ_ADDR_LSB];
  assign o_m_dat = req_q[REQ_DATA_MSB:REQ_DATA_LSB];

  assign o_req_ready = (state == MASTER_IDLE);
  assign o_rsp_valid = (state == MASTER_REPLY);

  always_comb begin
    o_rsp_flit                            = '0;
    o_rsp_flit[RSP_ERR_BIT]               = rsp_err_q;
    o_rsp_flit[RSP_DATA_MSB:RSP_DATA_LSB] = rsp_data_q;
  end

endmodule

`default_nettype wire

/* source/noc_wb_slave_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_wb_slave_adapter
  import noc_types_pkg::*, noc_map_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_s_cyc,
  input  logic          i_s_stb,
  input  logic          i_s_we,
  input  noc_addr_t     i_s_adr,
  input  noc_sel_t      i_s_sel,
  input  noc_data_t     i_s_dat,
  output noc_data_t     o_s_dat,
  output logic          o_s_ack,
  output logic          o_s_err,
  output logic          o_req_valid,
  output noc_req_flit_t o_req_flit,
  input  logic          i_req_ready,
  input  logic          i_rsp_valid,
  input  noc_rsp_flit_t i_rsp_flit,
  output logic          o_rsp_ready
);

  slave_state_e  state;
  noc_region_t   region;
  noc_id_x_t     dst_x;
  noc_id_y_t     dst_y;
  logic          unmapped;
  logic          req_take;
  logic          rsp_take;
  logic          err_q;
  noc_data_t     rdata_q;
  noc_req_flit_t req_flit_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign region = i_s_adr[REGION_MSB +: 2];

  always_comb begin
    dst_x    = '0;
    dst_y    = '0;
    unmapped = 1'b0;
    case (region)
      REGION0: begin
        dst_x = REGION0_ID_X;
        dst_y = REGION0_ID_Y;
      end
      REGION1: begin
        dst_x = REGION1_ID_X;
        dst_y = REGION1_ID_Y;
      end
      REGION2: begin
        dst_x = REGION2_ID_X;
        dst_y = REGION2_ID_Y;
      end
      default: unmapped = 1'b1;
    endcase
  end

  assign req_take = (state == SLAVE_IDLE) && i_s_cyc && i_s_stb;
  assign rsp_take = (state == SLAVE_WAIT_RSP) && i_rsp_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= SLAVE_IDLE;
      err_q <= 1'b0;
    end else begin
      case (state)
        SLAVE_IDLE: begin
          if (req_take) begin
            // unmapped region is answered here, no flit goes out.
            err_q <= unmapped;
            state <= unmapped ? SLAVE_DONE : SLAVE_SEND;
          end
        end
        SLAVE_SEND: begin
          if (i_req_ready) begin
            state <= SLAVE_WAIT_RSP;
          end
        end
        SLAVE_WAIT_RSP: begin
          if (rsp_take) begin
            err_q <= i_rsp_flit[RSP_ERR_BIT];
            state <= SLAVE_DONE;
          end
        end
        default: state <= SLAVE_IDLE;
      endcase
    end
  end

  // flit and read data.
  always_ff @(posedge i_clk) begin
    if (req_take) begin
      req_flit_q[REQ_WE_BIT]                  <= i_s_we;
      req_flit_q[REQ_SEL_MSB:REQ_SEL_LSB]     <= i_s_sel;
      req_flit_q[REQ_DST_X_MSB:REQ_DST_X_LSB] <= dst_x;
      req_flit_q[REQ_DST_Y_MSB:REQ_DST_Y_LSB] <= dst_y;
      req_flit_q[REQ_ADDR_MSB:REQ_ADDR_LSB]   <= i_s_adr;
      req_flit_q[REQ_DATA_MSB:REQ_DATA_LSB]   <= i_s_dat;
      rdata_q                                 <= '0;
    end else if (rsp_take) begin
      rdata_q <= i_rsp_flit[RSP_DATA_MSB:RSP_DATA_LSB];
    end
  end

  assign o_req_valid = (state == SLAVE_SEND);
  assign o_req_flit  = req_flit_q;
  assign o_rsp_ready = (state == SLAVE_WAIT_RSP);

  assign o_s_ack = (state == SLAVE_DONE) && !err_q;
  assign o_s_err = (state == SLAVE_DONE) && err_q;
  assign o_s_dat = rdata_q;

endmodule

`default_nettype wire
